// File: Bender.yml
package:
  name: cart_loader

sources:
  - src/cart_pkg.sv
  - src/cheat_pkg.sv
  - src/download_decoder.sv
  - src/rom_write_sequencer.sv
  - src/cheat_code_assembler.sv
  - src/cart_address_map.sv
  - src/cart_loader_top.sv
  - target: test
    files:
      - tb/cart_loader_assert.sv
      - tb/cart_loader_tb.sv

// File: src.f
src/cart_pkg.sv
src/cheat_pkg.sv
src/download_decoder.sv
src/rom_write_sequencer.sv
src/cheat_code_assembler.sv
src/cart_address_map.sv
src/cart_loader_top.sv
tb/cart_loader_assert.sv
tb/cart_loader_tb.sv

// File: src/cart_address_map.sv
`timescale 1ns/1ns

module cart_address_map (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_wr,
	input  logic                                 cart_end,
	input  logic [cart_pkg::download_addr_w-1:0] wr_addr,
	input  logic [cart_pkg::rom_addr_w-1:0]      cpu_rom_addr,
	output logic [cart_pkg::rom_addr_w-1:0]      mem_raddr
);
	import cart_pkg::*;

	localparam int hdr_bit = $clog2(header_size); // Address bit 9
	localparam logic [rom_addr_w-1:0] hdr_offset = rom_addr_w'(header_size);
	localparam logic [download_addr_w-1:0] hdr_first = download_addr_w'(header_size);

	logic [rom_addr_w-1:0] wr_rom_addr;
	logic [rom_addr_w-1:0] plain_mask;
	logic [rom_addr_w-1:0] header_mask;
	logic [rom_addr_w-1:0] mapped_addr;
	logic                  header_flag;

	assign wr_rom_addr = wr_addr[rom_addr_w-1:0];

	// ============================================================
	// Size masks, learned while the cartridge streams in
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			plain_mask  <= '0;
			header_mask <= '0;
			header_flag <= 1'b0;
		end else begin
			if (cart_wr) begin
				if (wr_addr == '0) begin
					plain_mask <= '0; // First byte restarts
				end else begin
					plain_mask <= plain_mask | wr_rom_addr;
				end
				if (wr_addr == hdr_first) begin
					header_mask <= '0; // First byte past the header
				end else begin
					header_mask <= header_mask | (wr_rom_addr - hdr_offset);
				end
			end
			if (cart_end) begin
				header_flag <= wr_addr[hdr_bit];
			end
		end
	end

	// Skip the copier header when present
	assign mapped_addr = header_flag ? ((cpu_rom_addr + hdr_offset) & header_mask)
	                                 : (cpu_rom_addr & plain_mask);

	always_ff @(posedge clk_sys) begin
		mem_raddr <= mapped_addr;
	end

endmodule

// File: src/cart_loader_top.sv
`timescale 1ns/1ns

module cart_loader_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download,
	input  logic [cart_pkg::index_w-1:0]         ioctl_index,
	input  logic                                 ioctl_wr,
	input  logic [cart_pkg::download_addr_w-1:0] ioctl_addr,
	input  logic [cart_pkg::byte_w-1:0]          ioctl_dout,
	input  logic                                 rom_we_ack,
	input  logic [cart_pkg::rom_addr_w-1:0]      cpu_rom_addr,
	output logic                                 ioctl_wait,
	output logic                                 rom_we,
	output logic [cart_pkg::rom_waddr_w-1:0]     rom_waddr,
	output logic [cart_pkg::byte_w-1:0]          rom_wdata,
	output logic [cart_pkg::rom_addr_w-1:0]      mem_raddr,
	output logic                                 gg,
	output cheat_pkg::cheat_code_t               cheat_code,
	output logic                                 cheat_valid,
	output logic                                 cheat_clear
);
	import cart_pkg::*;
	import cheat_pkg::*;

	logic                       cart_wr;
	logic                       code_wr;
	logic                       cart_start;
	logic                       cart_end;
	logic                       any_first_wr;
	logic [download_addr_w-1:0] wr_addr;
	logic [byte_w-1:0]          wr_data;

	// ============================================================
	// Host stream decode
	// ============================================================
	download_decoder download_decoder_inst (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_wr,
		.ioctl_addr, .ioctl_dout, .cart_wr, .code_wr, .cart_start,
		.cart_end, .any_first_wr, .wr_addr, .wr_data, .gg
	);

	// Cartridge bytes out to memory
	rom_write_sequencer rom_write_sequencer_inst (
		.clk_sys, .reset, .cart_wr, .cart_start, .wr_data, .rom_we_ack,
		.ioctl_wait, .rom_we, .rom_waddr, .rom_wdata
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk_sys, .reset, .code_wr, .any_first_wr,
		.wr_addr     (wr_addr[cheat_addr_w-1:0]),
		.wr_data, .cheat_code, .cheat_valid, .cheat_clear
	);

	// Console read side
	cart_address_map cart_address_map_inst (
		.clk_sys, .reset, .cart_wr, .cart_end, .wr_addr, .cpu_rom_addr, .mem_raddr
	);

endmodule

// File: src/cart_pkg.sv
package cart_pkg;

	// ============================================================
	// Address and data widths
	// ============================================================

	// Host download address, byte granular
	localparam int download_addr_w = 25;

	// Console ROM address and memory read address
	localparam int rom_addr_w = 22;

	localparam int rom_waddr_w = 24; // Memory write address
	localparam int byte_w      = 8;

	// ============================================================
	// Download index codes
	// ============================================================

	localparam int index_w = 8;

	// Cheat file slot
	localparam logic [index_w-1:0] code_index = '1;

	// Low index bits select the cartridge type
	localparam int gg_index_w = 5;
	localparam logic [gg_index_w-1:0] gg_index = 5'd2; // Game Gear cartridge

	// Copier header found on some dumps
	localparam int header_size = 512;

endpackage

// File: src/cheat_code_assembler.sv
`timescale 1ns/1ns

module cheat_code_assembler (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 code_wr,
	input  logic                                 any_first_wr,
	input  logic [cheat_pkg::cheat_addr_w-1:0]   wr_addr,
	input  logic [7:0]                           wr_data,
	output cheat_pkg::cheat_code_t               cheat_code,
	output logic                                 cheat_valid,
	output logic                                 cheat_clear
);
	import cheat_pkg::*;

	logic [cheat_addr_w-1:0] lane_sel;
	logic                    last_byte;

	// Record byte k lands in field k/4, byte k mod 4 from the bottom
	// Field 0 (flags) sits in the top lanes, so the field bits invert
	assign lane_sel  = {~wr_addr[cheat_addr_w-1 -: 2], wr_addr[1:0]};
	assign last_byte = (wr_addr == cheat_addr_w'(cheat_bytes - 1));

	// ============================================================
	// Record assembly
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat_code.lanes[lane_sel] <= wr_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr & last_byte; // Record complete
			cheat_clear <= any_first_wr;        // New download drops old codes
		end
	end

endmodule

// File: src/cheat_pkg.sv
package cheat_pkg;

	// ============================================================
	// Cheat record layout
	// ============================================================

	localparam int cheat_bytes  = 16; // Bytes per record
	localparam int cheat_addr_w = $clog2(cheat_bytes);

	typedef logic [31:0] cheat_field_t;

	// Most significant field first
	typedef struct packed {
		cheat_field_t flags;
		cheat_field_t address;
		cheat_field_t compare;
		cheat_field_t replace;
	} cheat_fields_t;

	// Filled a byte at a time, read back as fields
	typedef union packed {
		cheat_fields_t fields;
		logic [cheat_bytes-1:0][7:0] lanes;
	} cheat_code_t;

endpackage

// File: src/download_decoder.sv
`timescale 1ns/1ns

module download_decoder (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                ioctl_download,
	input  logic [cart_pkg::index_w-1:0]        ioctl_index,
	input  logic                                ioctl_wr,
	input  logic [cart_pkg::download_addr_w-1:0] ioctl_addr,
	input  logic [cart_pkg::byte_w-1:0]         ioctl_dout,
	output logic                                cart_wr,
	output logic                                code_wr,
	output logic                                cart_start,
	output logic                                cart_end,
	output logic                                any_first_wr,
	output logic [cart_pkg::download_addr_w-1:0] wr_addr,
	output logic [cart_pkg::byte_w-1:0]         wr_data,
	output logic                                gg
);
	import cart_pkg::*;

	logic code_sel;
	logic cart_download;
	logic cart_download_q; // Previous cartridge download level

	assign code_sel      = (ioctl_index == code_index);
	assign cart_download = ioctl_download & ~code_sel;

	// ============================================================
	// Strobes, one cycle behind the host
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download_q <= 1'b0;
			cart_wr         <= 1'b0;
			code_wr         <= 1'b0;
			cart_start      <= 1'b0;
			cart_end        <= 1'b0;
			any_first_wr    <= 1'b0;
			gg              <= 1'b0;
		end else begin
			cart_download_q <= cart_download;
			cart_wr         <= ioctl_wr & cart_download;
			code_wr         <= ioctl_wr & ioctl_download & code_sel;
			cart_start      <= cart_download & ~cart_download_q; // Rising edge
			cart_end        <= ~cart_download & cart_download_q; // Falling edge
			any_first_wr    <= ioctl_wr & ioctl_download & (ioctl_addr == '0);
			if (ioctl_wr & cart_download) begin
				gg <= (ioctl_index[gg_index_w-1:0] == gg_index);
			end
		end
	end

	// Holds the last written byte and address
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			wr_addr <= ioctl_addr;
			wr_data <= ioctl_dout;
		end
	end

endmodule

// File: src/rom_write_sequencer.sv
`timescale 1ns/1ns

module rom_write_sequencer (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            cart_wr,
	input  logic                            cart_start,
	input  logic [cart_pkg::byte_w-1:0]     wr_data,
	input  logic                            rom_we_ack,
	output logic                            ioctl_wait,
	output logic                            rom_we,
	output logic [cart_pkg::rom_waddr_w-1:0] rom_waddr,
	output logic [cart_pkg::byte_w-1:0]     rom_wdata
);

	logic ack_seen;

	// Memory has caught up with the last toggle
	assign ack_seen = ioctl_wait & (rom_we == rom_we_ack);

	// ============================================================
	// Toggle handshake and host wait
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait <= 1'b0;
			rom_we     <= 1'b0;
		end else if (cart_wr) begin
			ioctl_wait <= 1'b1; // Hold the host off
			rom_we     <= ~rom_we; // New request
		end else if (ack_seen) begin
			ioctl_wait <= 1'b0;
		end
	end

	// Write address advances once per acknowledge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_waddr <= '0;
		end else if (cart_start) begin
			rom_waddr <= '0;
		end else if (!cart_wr && ack_seen) begin
			rom_waddr <= rom_waddr + 1'b1;
		end
	end

	// Byte stays stable until the next request
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_wdata <= wr_data;
		end
	end

endmodule

// File: tb/cart_loader_assert.sv
`timescale 1ns/1ns

module cart_loader_assert (
	input logic                             clk_sys,
	input logic                             reset,
	input logic                             cart_start,
	input logic                             ioctl_wait,
	input logic                             rom_we,
	input logic                             rom_we_ack,
	input logic [cart_pkg::rom_waddr_w-1:0] rom_waddr
);

	int unsigned fail_count = 0; // Failed checks so far

	// Host released only after the memory caught up
	wait_release: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(ioctl_wait) |-> $past(rom_we == rom_we_ack))
	else begin
		$error("ioctl_wait fell while rom_we_ack still differed from rom_we");
		fail_count++;
	end

	// New request together with a rising wait
	toggle_with_wait: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_we != $past(rom_we)) |-> $rose(ioctl_wait))
	else begin
		$error("rom_we toggled without ioctl_wait rising");
		fail_count++;
	end

	waddr_step: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_waddr != $past(rom_waddr)) |-> ($fell(ioctl_wait) || $past(cart_start)))
	else begin
		$error("rom_waddr moved outside an acknowledge or download start");
		fail_count++;
	end

endmodule

// File: tb/cart_loader_tb.sv
`timescale 1ns/1ns

module cart_loader_tb;
	import cart_pkg::*;
	import cheat_pkg::*;

	localparam int cart_loads  = 5;
	localparam int cheat_loads = 2;
	localparam int records     = 3; // Per cheat download

	logic                       clk_sys, reset, ioctl_download, ioctl_wr, rom_we_ack;
	logic [index_w-1:0]         ioctl_index;
	logic [download_addr_w-1:0] ioctl_addr;
	logic [byte_w-1:0]          ioctl_dout, rom_wdata;
	logic [rom_addr_w-1:0]      cpu_rom_addr, mem_raddr;
	logic [rom_waddr_w-1:0]     rom_waddr;
	logic                       ioctl_wait, rom_we, gg, cheat_valid, cheat_clear;
	cheat_code_t                cheat_code;

	// ============================================================
	// Reference model and memory model state
	// ============================================================
	logic [byte_w-1:0]     exp_bytes[$];
	logic [byte_w-1:0]     mem_bytes[$]; // Bytes of the current download
	cheat_code_t           exp_records[$];
	logic [rom_addr_w-1:0] plain_m  = '0;
	logic [rom_addr_w-1:0] header_m = '0;
	logic                  hdr_flag = 1'b0;
	logic                  gg_exp   = 1'b0;
	logic                  we_seen  = 1'b0;
	int                    ack_delay = -1; // Negative when no request is open
	int                    valid_count, clear_count, cycle_count, cycle_limit;
	int unsigned           assert_fails;

	cart_loader_top cart_loader_top_inst (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr,
		.ioctl_dout, .rom_we_ack, .cpu_rom_addr, .ioctl_wait, .rom_we, .rom_waddr,
		.rom_wdata, .mem_raddr, .gg, .cheat_code, .cheat_valid, .cheat_clear
	);

	bind rom_write_sequencer cart_loader_assert cart_loader_assert_inst (
		.clk_sys, .reset, .cart_start, .ioctl_wait, .rom_we, .rom_we_ack, .rom_waddr
	);

	assign assert_fails =
		cart_loader_top_inst.rom_write_sequencer_inst.cart_loader_assert_inst.fail_count;

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic stop_on_error(string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic compare_byte(string name, logic [byte_w-1:0] got, logic [byte_w-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic compare_waddr(string name, logic [rom_waddr_w-1:0] got,
			logic [rom_waddr_w-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic compare_raddr(string name, logic [rom_addr_w-1:0] got,
			logic [rom_addr_w-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic compare_cheat(string name, cheat_code_t got, cheat_code_t exp);
		if (got !== exp)
			stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic compare_flag(string name, logic got, logic exp);
		if (got !== exp)
			stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic host_write(int addr, logic [byte_w-1:0] data, bit hold);
		ioctl_wr   = 1'b1;
		ioctl_addr = download_addr_w'(addr);
		ioctl_dout = data;
		step();
		ioctl_wr = 1'b0;
		if (hold) begin
			while (!ioctl_wait) step(); // Wait rises two cycles after the strobe
			while (ioctl_wait) step();
		end
	endtask

	task automatic cart_download(int size, logic [index_w-1:0] index);
		logic [byte_w-1:0]          data;
		logic [rom_addr_w-1:0]      a;
		logic [download_addr_w-1:0] last;
		mem_bytes.delete();
		ioctl_index    = index;
		ioctl_download = 1'b1;
		repeat (2) step();
		for (int i = 0; i < size; i++) begin
			data     = byte_w'($urandom);
			a        = rom_addr_w'(i);
			plain_m  = (i == 0) ? '0 : (plain_m | a);
			header_m = (i == header_size) ? '0 : (header_m | (a - rom_addr_w'(header_size)));
			exp_bytes.push_back(data);
			host_write(i, data, 1'b1);
		end
		ioctl_download = 1'b0;
		repeat (3) step();
		last     = download_addr_w'(size - 1);
		hdr_flag = last[$clog2(header_size)]; // Bit 9 of the last address
		gg_exp   = (index[gg_index_w-1:0] == gg_index);
		if (mem_bytes.size() != size)
			stop_on_error($sformatf("Memory holds %0d bytes after a %0d byte download",
				mem_bytes.size(), size));
		compare_flag("gg", gg, gg_exp);
	endtask

	task automatic cheat_download(int count);
		cheat_field_t      f[4];
		cheat_code_t       rec;
		logic [byte_w-1:0] data;
		ioctl_index    = code_index;
		ioctl_download = 1'b1;
		repeat (2) step();
		for (int k = 0; k < count * cheat_bytes; k++) begin
			data = byte_w'($urandom);
			f[(k % cheat_bytes) / 4][8 * (k % 4) +: 8] = data;
			if (k % cheat_bytes == cheat_bytes - 1) begin
				rec.fields = '{flags: f[0], address: f[1], compare: f[2], replace: f[3]};
				exp_records.push_back(rec);
			end
			host_write(k, data, 1'b0);
		end
		ioctl_download = 1'b0;
		repeat (3) step();
		compare_flag("gg", gg, gg_exp); // Cheats leave the cartridge type alone
	endtask

	task automatic check_map(int count);
		logic [rom_addr_w-1:0] cpu;
		repeat (count) begin
			cpu          = rom_addr_w'($urandom);
			cpu_rom_addr = cpu;
			step();
			compare_raddr("mem_raddr", mem_raddr, hdr_flag ?
				((cpu + rom_addr_w'(header_size)) & header_m) : (cpu & plain_m));
		end
	endtask

	// ============================================================
	// Memory model, record checks and run limit
	// ============================================================
	initial begin
		forever begin
			step();
			cycle_count++;
			if (cycle_limit != 0 && cycle_count > cycle_limit)
				stop_on_error("Timeout: the run went past its cycle limit");
			if (assert_fails != 0)
				stop_on_error("A handshake assertion on the write sequencer failed");
			if (!reset && rom_we !== we_seen) begin
				if (ack_delay >= 0 || exp_bytes.size() == 0)
					stop_on_error("Memory request toggled while no write was due");
				compare_waddr("rom_waddr", rom_waddr, rom_waddr_w'(mem_bytes.size()));
				compare_byte("rom_wdata", rom_wdata, exp_bytes.pop_front());
				mem_bytes.push_back(rom_wdata);
				we_seen   = rom_we;
				ack_delay = $urandom_range(5, 0);
			end
			if (ack_delay == 0)
				rom_we_ack = we_seen;
			if (ack_delay >= 0)
				ack_delay--;
			if (cheat_valid) begin
				if (exp_records.size() == 0)
					stop_on_error("cheat_valid pulsed with no complete record sent");
				compare_cheat("cheat_code", cheat_code, exp_records.pop_front());
				valid_count++;
			end
			if (cheat_clear)
				clear_count++;
		end
	end

	initial begin
		int                 sizes[cart_loads];
		logic [index_w-1:0] indexes[cart_loads];
		void'($urandom(32'h23eb7ce4));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_we_ack     = 1'b0;
		cpu_rom_addr   = '0;
		// 512-byte header plus 512 bytes, so bit 9 of the last address is set
		sizes   = '{1024, 256, 0, 0, 0}; // Header case, plain case, then random
		indexes = '{8'h22, 8'h01, 8'h42, 8'h00, 8'h00};
		for (int i = 2; i < cart_loads; i++) begin
			sizes[i] = $urandom_range(1600, 64);
			if (i > 2)
				indexes[i] = index_w'($urandom_range(254, 0));
		end
		cycle_limit = (sizes.sum() + cheat_loads * records * cheat_bytes) * 10 + 2000;
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		step();
		compare_flag("ioctl_wait", ioctl_wait, 1'b0);
		compare_flag("rom_we", rom_we, 1'b0);
		compare_flag("cheat_valid", cheat_valid, 1'b0);
		compare_flag("cheat_clear", cheat_clear, 1'b0);
		compare_flag("gg", gg, 1'b0);
		check_map(8); // Masks start clear
		for (int i = 0; i < cart_loads; i++) begin
			cart_download(sizes[i], indexes[i]);
			check_map(20);
			if (i == 1 || i == cart_loads - 1)
				cheat_download(records);
		end
		if (valid_count != cheat_loads * records || clear_count != cart_loads + cheat_loads) begin
			stop_on_error($sformatf("Saw %0d record and %0d clear pulses, expected %0d and %0d",
				valid_count, clear_count, cheat_loads * records, cart_loads + cheat_loads));
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule
